/* apbPeriph_cfg.svh */
`ifndef APBPERIPH_CFG_SVH
`define APBPERIPH_CFG_SVH

// APB bus widths
`define APB_ADDR_W 16
`define APB_DATA_W 32

// Peripheral slots, decoded from address bits 15:12
`define SLOT_LED    1
`define SLOT_BUTTON 2

// LED output width
`define LED_W 4

// Clocks the synchronized key must hold before the level is accepted
`define DEBOUNCE_CYCLES 16

`endif

/* apbPeriphPkg.sv */
`default_nettype none

`include "apbPeriph_cfg.svh"

package apbPeriphPkg;

    // Bus words
    typedef logic [`APB_ADDR_W-1:0] apbAddrT;
    typedef logic [`APB_DATA_W-1:0] apbDataT;

    // Slot number from paddr[15:12]
    typedef logic [3:0] slotT;

    // Word offset inside a slot, paddr[11:2]
    typedef logic [9:0] regOffT;

    typedef logic [`LED_W-1:0] ledT;

    // Button register map
    typedef enum logic [9:0] {
        STATUS  = 10'd0,
        CTRL    = 10'd1,
        PENDING = 10'd2
    } buttonRegE;

endpackage

`default_nettype wire

/* apbSlotDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apbPeriph_cfg.svh"

module apbSlotDecoder
    import apbPeriphPkg::*;
(
    input  wire apbAddrT paddr,
    input  wire          psel,

    // Responses from the peripherals
    input  wire apbDataT ledRdata,
    input  wire          ledSlvErr,
    input  wire apbDataT buttonRdata,
    input  wire          buttonSlvErr,

    output logic         selLed,
    output logic         selButton,
    output apbDataT      prdata,
    output logic         pready,
    output logic         pslverr
);

    slotT slot;

    // Top nibble of the address picks the peripheral
    assign slot = paddr[`APB_ADDR_W-1 -: 4];

    assign selLed    = psel && (slot == slotT'(`SLOT_LED));
    assign selButton = psel && (slot == slotT'(`SLOT_BUTTON));

    // No wait states in this subsystem
    assign pready = 1'b1;

    //----------------------------------------------------------------------
    // Response merge
    //----------------------------------------------------------------------
    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (psel) begin
            case (slot)
                slotT'(`SLOT_LED): begin
                    prdata  = ledRdata;
                    pslverr = ledSlvErr;
                end
                slotT'(`SLOT_BUTTON): begin
                    prdata  = buttonRdata;
                    pslverr = buttonSlvErr;
                end
                // Unmapped slot, zero data with an error
                default: begin
                    pslverr = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* ledRegs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apbPeriph_cfg.svh"

module ledRegs
    import apbPeriphPkg::*;
(
    input  wire          clk,
    input  wire          RSTn,

    // APB side, already decoded to this slot
    input  wire          sel,
    input  wire          penable,
    input  wire          pwrite,
    input  wire regOffT  regOff,
    input  wire apbDataT pwdata,
    output apbDataT      rdata,
    output logic         slvErr,

    output ledT          ledNumOut
);

    ledT  ledReg;
    logic offHit;
    logic wrEn;

    // Single register at word 0
    assign offHit = (regOff == '0);
    assign wrEn   = sel && penable && pwrite && offHit;

    //----------------------------------------------------------------------
    // LED pattern register
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            ledReg <= '0;
        end else if (wrEn) begin
            ledReg <= pwdata[`LED_W-1:0];
        end
    end

    assign ledNumOut = ledReg;

    // Read back zero-extended
    assign rdata = (sel && offHit) ? {{(`APB_DATA_W-`LED_W){1'b0}}, ledReg} : '0;

    // Anything past word 0 is an error
    assign slvErr = sel && penable && !offHit;

endmodule

`default_nettype wire

/* keyDebounce.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apbPeriph_cfg.svh"

module keyDebounce (
    input  wire  clk,
    input  wire  RSTn,
    input  wire  key,

    output logic keyLevel,
    output logic keyRise,
    output logic keyFall
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

    logic             keyMeta;
    logic             keySync;
    logic [CNT_W-1:0] stableCnt;
    logic             differs;
    logic             cntDone;

    //----------------------------------------------------------------------
    // Two-flop synchronizer
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            keyMeta <= 1'b0;
            keySync <= 1'b0;
        end else begin
            keyMeta <= key;
            keySync <= keyMeta;
        end
    end

    assign differs = (keySync != keyLevel);
    assign cntDone = (stableCnt == CNT_W'(`DEBOUNCE_CYCLES - 1));

    //----------------------------------------------------------------------
    // Stability counter and accepted level
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            stableCnt <= '0;
            keyLevel  <= 1'b0;
            keyRise   <= 1'b0;
            keyFall   <= 1'b0;
        end else begin
            keyRise <= 1'b0;
            keyFall <= 1'b0;
            if (!differs) begin
                // Glitch ended, start over
                stableCnt <= '0;
            end else if (cntDone) begin
                stableCnt <= '0;
                keyLevel  <= keySync;
                keyRise   <= keySync;
                keyFall   <= !keySync;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* buttonRegs.sv */
`timescale 1ns/100ps
`default_nettype none

module buttonRegs
    import apbPeriphPkg::*;
(
    input  wire          clk,
    input  wire          RSTn,

    // APB side, already decoded to this slot
    input  wire          sel,
    input  wire          penable,
    input  wire          pwrite,
    input  wire regOffT  regOff,
    input  wire apbDataT pwdata,
    output apbDataT      rdata,
    output logic         slvErr,

    // From the debounce logic
    input  wire          keyLevel,
    input  wire          keyRise,
    input  wire          keyFall,

    output logic         keyIrq
);

    buttonRegE regSel;
    logic      access;
    logic      wrAccess;
    logic      irqEn;
    logic      fallSel;
    logic      pending;
    logic      edgeHit;
    logic      pendClr;

    assign regSel   = buttonRegE'(regOff);
    assign access   = sel && penable;
    assign wrAccess = access && pwrite;

    //----------------------------------------------------------------------
    // CTRL, bit 0 irq enable, bit 1 falling edge select
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            irqEn   <= 1'b0;
            fallSel <= 1'b0;
        end else if (wrAccess && (regSel == CTRL)) begin
            irqEn   <= pwdata[0];
            fallSel <= pwdata[1];
        end
    end

    //----------------------------------------------------------------------
    // PENDING, write one to clear
    //----------------------------------------------------------------------
    assign edgeHit = fallSel ? keyFall : keyRise;
    assign pendClr = wrAccess && (regSel == PENDING) && pwdata[0];

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            pending <= 1'b0;
        end else if (edgeHit) begin
            // A new edge beats a clear in the same cycle
            pending <= 1'b1;
        end else if (pendClr) begin
            pending <= 1'b0;
        end
    end

    assign keyIrq = pending && irqEn;

    //----------------------------------------------------------------------
    // Read mux and error
    //----------------------------------------------------------------------
    always_comb begin
        rdata  = '0;
        slvErr = 1'b0;
        if (sel) begin
            case (regSel)
                STATUS: begin
                    rdata[0] = keyLevel;
                end
                CTRL: begin
                    rdata[0] = irqEn;
                    rdata[1] = fallSel;
                end
                PENDING: begin
                    rdata[0] = pending;
                end
                default: begin
                    slvErr = access;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* apbPeriphTop.sv */
`timescale 1ns/100ps
`default_nettype none

module apbPeriphTop
    import apbPeriphPkg::*;
(
    input  wire          clk,
    input  wire          RSTn,

    // APB completer port
    input  wire apbAddrT paddr,
    input  wire          psel,
    input  wire          penable,
    input  wire          pwrite,
    input  wire apbDataT pwdata,
    output wire apbDataT prdata,
    output wire          pready,
    output wire          pslverr,

    // Board side
    output wire ledT     ledNumOut,
    input  wire          key,
    output wire          keyIrq
);

    wire          selLed;
    wire          selButton;
    wire apbDataT ledRdata;
    wire          ledSlvErr;
    wire apbDataT buttonRdata;
    wire          buttonSlvErr;

    wire          keyLevel;
    wire          keyRise;
    wire          keyFall;

    //----------------------------------------------------------------------
    // Slot decode
    //----------------------------------------------------------------------
    apbSlotDecoder u_apbSlotDecoder (
        .paddr        (paddr),
        .psel         (psel),
        .ledRdata     (ledRdata),
        .ledSlvErr    (ledSlvErr),
        .buttonRdata  (buttonRdata),
        .buttonSlvErr (buttonSlvErr),
        .selLed       (selLed),
        .selButton    (selButton),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

    //----------------------------------------------------------------------
    // Slot 1, LED
    //----------------------------------------------------------------------
    ledRegs u_ledRegs (
        .clk       (clk),
        .RSTn      (RSTn),
        .sel       (selLed),
        .penable   (penable),
        .pwrite    (pwrite),
        .regOff    (paddr[11:2]),
        .pwdata    (pwdata),
        .rdata     (ledRdata),
        .slvErr    (ledSlvErr),
        .ledNumOut (ledNumOut)
    );

    //----------------------------------------------------------------------
    // Slot 2, button
    //----------------------------------------------------------------------
    keyDebounce u_keyDebounce (
        .clk      (clk),
        .RSTn     (RSTn),
        .key      (key),
        .keyLevel (keyLevel),
        .keyRise  (keyRise),
        .keyFall  (keyFall)
    );

    buttonRegs u_buttonRegs (
        .clk      (clk),
        .RSTn     (RSTn),
        .sel      (selButton),
        .penable  (penable),
        .pwrite   (pwrite),
        .regOff   (paddr[11:2]),
        .pwdata   (pwdata),
        .keyLevel (keyLevel),
        .keyRise  (keyRise),
        .keyFall  (keyFall),
        .rdata    (buttonRdata),
        .slvErr   (buttonSlvErr),
        .keyIrq   (keyIrq)
    );

endmodule

`default_nettype wire

/* tbApbPeriph.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apbPeriph_cfg.svh"

module tbApbPeriph
    import apbPeriphPkg::*;
();

    localparam int DB = `DEBOUNCE_CYCLES;
    // All tests together need roughly 400 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    // Slot in bits 15:12, word offset in bits 11:2
    localparam apbAddrT LED_ADDR     = apbAddrT'(`SLOT_LED << 12);
    localparam apbAddrT STATUS_ADDR  = apbAddrT'((`SLOT_BUTTON << 12) + 4 * 0);
    localparam apbAddrT CTRL_ADDR    = apbAddrT'((`SLOT_BUTTON << 12) + 4 * 1);
    localparam apbAddrT PENDING_ADDR = apbAddrT'((`SLOT_BUTTON << 12) + 4 * 2);

    logic    clk;
    logic    RSTn;
    apbAddrT paddr;
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbDataT pwdata;
    apbDataT prdata;
    logic    pready;
    logic    pslverr;
    ledT     ledNumOut;
    logic    key;
    logic    keyIrq;

    int      errCount;
    int      checkCount;
    int      cycleCnt = 0;
    ledT     ledModel;

    apbPeriphTop u_dut (
        .clk       (clk),
        .RSTn      (RSTn),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ledNumOut (ledNumOut),
        .key       (key),
        .keyIrq    (keyIrq)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic checkValue(input string name, input apbDataT expVal,
                              input apbDataT actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic reportError(input string msg);
        errCount++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Setup phase, then access phase until pready
    task automatic apbTransfer(input apbAddrT addr, input logic write, input apbDataT wdata,
                               output apbDataT rdata, output logic err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (pready !== 1'b1) @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input apbDataT data, output logic err);
        apbDataT unused;
        apbTransfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
        apbTransfer(addr, 1'b0, '0, data, err);
    endtask

    task automatic expectRead(input string name, input apbAddrT addr, input apbDataT expVal);
        apbDataT data;
        logic    err;
        apbRead(addr, data, err);
        checkValue({name, " pslverr"}, 32'd0, apbDataT'(err));
        checkValue(name, expVal, data);
    endtask

    // Poll STATUS until the debounced level matches
    task automatic waitKeyLevel(input logic level, input int maxCycles);
        apbDataT data;
        logic    err;
        int      n;
        n = 0;
        do begin
            apbRead(STATUS_ADDR, data, err);
            n += 2;
        end while (data[0] !== level && n < maxCycles);
        if (data[0] !== level) begin
            reportError($sformatf("STATUS did not reach %0d within %0d cycles", level, maxCycles));
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic testReset();
        checkValue("ledNumOut", 32'd0, apbDataT'(ledNumOut));
        checkValue("keyIrq", 32'd0, apbDataT'(keyIrq));
        checkValue("pslverr", 32'd0, apbDataT'(pslverr));
        expectRead("CTRL", CTRL_ADDR, 32'd0);
    endtask

    task automatic testLed();
        apbDataT pattern;
        apbDataT data;
        logic    err;
        repeat (8) begin
            pattern  = $urandom;
            ledModel = pattern[`LED_W-1:0];
            apbWrite(LED_ADDR, pattern, err);
            checkValue("LED write pslverr", 32'd0, apbDataT'(err));
            checkValue("ledNumOut", apbDataT'(ledModel), apbDataT'(ledNumOut));
            expectRead("LED", LED_ADDR, apbDataT'(ledModel));
        end
        // Word 1 of the LED slot holds no register
        apbRead(LED_ADDR + 16'h4, data, err);
        checkValue("LED offset 1 read pslverr", 32'd1, apbDataT'(err));
        checkValue("LED offset 1 prdata", 32'd0, data);
        apbWrite(LED_ADDR + 16'h4, apbDataT'(~ledModel), err);
        checkValue("LED offset 1 write pslverr", 32'd1, apbDataT'(err));
        checkValue("ledNumOut", apbDataT'(ledModel), apbDataT'(ledNumOut));
    endtask

    task automatic testUnmapped();
        slotT    slots[3] = '{4'd0, 4'd3, 4'd15};
        apbAddrT addr;
        apbDataT data;
        logic    err;
        foreach (slots[i]) begin
            addr = apbAddrT'(slots[i]) << 12;
            apbWrite(addr, $urandom, err);
            checkValue("unmapped write pslverr", 32'd1, apbDataT'(err));
            checkValue("ledNumOut", apbDataT'(ledModel), apbDataT'(ledNumOut));
            apbRead(addr, data, err);
            checkValue("unmapped read pslverr", 32'd1, apbDataT'(err));
            checkValue("unmapped prdata", 32'd0, data);
        end
    endtask

    task automatic testPress();
        logic err;
        int   n;
        apbWrite(CTRL_ADDR, 32'h1, err);
        key = 1'b1;
        n   = 0;
        while (keyIrq !== 1'b1 && n < DB + 4) begin
            waitCycles(1);
            n++;
        end
        if (keyIrq !== 1'b1) begin
            reportError($sformatf("keyIrq did not rise within %0d cycles", DB + 4));
        end else if (n < DB + 2) begin
            reportError($sformatf("keyIrq rose after %0d cycles, debounce too short", n));
        end
        expectRead("STATUS", STATUS_ADDR, 32'd1);
        expectRead("PENDING", PENDING_ADDR, 32'd1);
        apbWrite(PENDING_ADDR, 32'h1, err);
        checkValue("keyIrq", 32'd0, apbDataT'(keyIrq));
        expectRead("PENDING", PENDING_ADDR, 32'd0);
        // Release is not the selected edge
        key = 1'b0;
        waitKeyLevel(1'b0, DB + 8);
        expectRead("PENDING", PENDING_ADDR, 32'd0);
    endtask

    task automatic testDebounce();
        int width;
        repeat (6) begin
            width = 1 + int'($urandom % (DB - 2));
            key   = 1'b1;
            waitCycles(width);
            key   = 1'b0;
            waitCycles(4);
        end
        waitCycles(DB + 4);
        expectRead("STATUS", STATUS_ADDR, 32'd0);
        expectRead("PENDING", PENDING_ADDR, 32'd0);
        checkValue("keyIrq", 32'd0, apbDataT'(keyIrq));
    endtask

    task automatic testEdgeSelect();
        logic err;
        // Falling edge, interrupt masked
        apbWrite(CTRL_ADDR, 32'h2, err);
        key = 1'b1;
        waitKeyLevel(1'b1, DB + 8);
        expectRead("PENDING", PENDING_ADDR, 32'd0);
        key = 1'b0;
        waitKeyLevel(1'b0, DB + 8);
        waitCycles(1);
        expectRead("PENDING", PENDING_ADDR, 32'd1);
        checkValue("keyIrq", 32'd0, apbDataT'(keyIrq));
        apbWrite(CTRL_ADDR, 32'h3, err);
        checkValue("keyIrq", 32'd1, apbDataT'(keyIrq));
        expectRead("CTRL", CTRL_ADDR, 32'd3);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(37));
        RSTn       = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        key        = 1'b0;
        ledModel   = '0;
        errCount   = 0;
        checkCount = 0;
        repeat (4) @(posedge clk);
        #1;
        RSTn = 1'b1;

        testReset();
        testLed();
        testUnmapped();
        testPress();
        testDebounce();
        testEdgeSelect();

        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
apbPeriphPkg.sv
apbSlotDecoder.sv
ledRegs.sv
keyDebounce.sv
buttonRegs.sv
apbPeriphTop.sv
tbApbPeriph.sv

/* run.sh */
#!/bin/sh
# Build and run the APB peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    -f compile.f --top-module tbApbPeriph -o simApbPeriph

./obj_dir/simApbPeriph | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
